//--- testbench/tb_vec_tasks.svh
// Testbench tasks for the vector coprocessor
// Host port driver, bounded waits, typed compares and a shadow model
// of the vector registers and the vector length

`ifndef TB_VEC_TASKS_SVH
`define TB_VEC_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Shadow model
//////////////////////////////////////////////////////////////////////

elen_t model_rf [NR_VREGS][VLMAX];
vlen_t model_vl;

// Requested length limited to the register size
function automatic vlen_t clamp_vl(input elen_t avl);
  if (avl > elen_t'(VLMAX)) begin
    return vlen_t'(VLMAX);
  end
  return vlen_t'(avl);
endfunction

// One element result, a is the vs2 element and b the vs1 element
function automatic elen_t elem_op(input vop_e op, input elen_t a, input elen_t b,
                                  input elen_t scalar);
  case (op)
    VMVX:    return scalar;
    VADD:    return a + b;
    VSUB:    return a - b;
    VAND:    return a & b;
    VOR:     return a | b;
    VXOR:    return a ^ b;
    default: return a;
  endcase
endfunction

// Body elements only, the tail keeps its old value
task automatic apply_model(input vop_e op, input vreg_t vd, input vreg_t vs1,
                           input vreg_t vs2, input elen_t scalar);
  if (op inside {VMVX, VADD, VSUB, VAND, VOR, VXOR}) begin
    for (int i = 0; i < int'(model_vl); i++) begin
      model_rf[vd][i] = elem_op(op, model_rf[vs2][i], model_rf[vs1][i], scalar);
    end
  end
endtask

function automatic elen_t expected_redsum(input vreg_t vs2, input elen_t seed);
  elen_t sum;
  sum = seed;
  for (int i = 0; i < int'(model_vl); i++) begin
    sum = sum + model_rf[vs2][i];
  end
  return sum;
endfunction

//////////////////////////////////////////////////////////////////////
// Compares
//////////////////////////////////////////////////////////////////////

task automatic check_data(input string name, input elen_t exp, input elen_t act);
  n_checks++;
  if (act !== exp) begin
    n_errors++;
    $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, act);
  end
endtask

task automatic check_vl(input string name, input vlen_t exp, input vlen_t act);
  n_checks++;
  if (act !== exp) begin
    n_errors++;
    $display("ERR %s expected %0d actual %0d", name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  n_checks++;
  if (act !== exp) begin
    n_errors++;
    $display("ERR %s expected %b actual %b", name, exp, act);
  end
endtask

task automatic check_count(input string name, input int unsigned exp,
                           input int unsigned act);
  n_checks++;
  if (act != exp) begin
    n_errors++;
    $display("ERR %s expected %0d actual %0d", name, exp, act);
  end
endtask

//////////////////////////////////////////////////////////////////////
// Host port and waits
//////////////////////////////////////////////////////////////////////

// Holds the instruction until the edge where ready is seen
task automatic send_insn(input string name, input vop_e op, input vreg_t vd,
                         input vreg_t vs1, input vreg_t vs2, input elen_t scalar);
  int unsigned cycles;
  logic        taken;
  cycles = 0;
  taken  = 1'b0;
  @(posedge clk_i);
  insn_valid_i  <= 1'b1;
  insn_op_i     <= op;
  insn_vd_i     <= vd;
  insn_vs1_i    <= vs1;
  insn_vs2_i    <= vs2;
  insn_scalar_i <= scalar;
  while (!taken && cycles < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    taken = insn_ready_o;
    @(posedge clk_i);
    cycles++;
  end
  insn_valid_i <= 1'b0;
  if (!taken) begin
    n_errors++;
    $display("%s: instruction not accepted within %0d cycles", name, TIMEOUT_CYCLES);
  end
endtask

task automatic wait_resp(input string name, output elen_t data);
  int unsigned cycles;
  logic        seen;
  cycles = 0;
  seen   = 1'b0;
  data   = '0;
  while (!seen && cycles < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    if (resp_valid_o) begin
      seen = 1'b1;
      data = resp_data_o;
    end
    cycles++;
  end
  if (!seen) begin
    n_errors++;
    $display("%s: no response within %0d cycles", name, TIMEOUT_CYCLES);
  end
endtask

task automatic wait_idle(input string name);
  int unsigned cycles;
  logic        seen;
  cycles = 0;
  seen   = 1'b0;
  while (!seen && cycles < TIMEOUT_CYCLES) begin
    @(negedge clk_i);
    seen = idle_o;
    cycles++;
  end
  if (!seen) begin
    n_errors++;
    $display("%s: core not idle within %0d cycles", name, TIMEOUT_CYCLES);
  end
endtask

//////////////////////////////////////////////////////////////////////
// Instruction level helpers
//////////////////////////////////////////////////////////////////////

task automatic set_vl(input string name, input elen_t avl);
  elen_t data;
  vlen_t exp;
  exp = clamp_vl(avl);
  send_insn(name, VSETVL, '0, '0, '0, avl);
  wait_resp(name, data);
  check_vl(name, exp, vlen_t'(data));
  model_vl = exp;
endtask

task automatic issue_vec(input string name, input vop_e op, input vreg_t vd,
                         input vreg_t vs1, input vreg_t vs2, input elen_t scalar);
  send_insn(name, op, vd, vs1, vs2, scalar);
  apply_model(op, vd, vs1, vs2, scalar);
endtask

task automatic scalar_result(input string name, input vop_e op, input vreg_t vs2,
                             input elen_t seed, input elen_t exp);
  elen_t data;
  send_insn(name, op, '0, '0, vs2, seed);
  wait_resp(name, data);
  check_data(name, exp, data);
endtask

task automatic report_test(input string name, input int unsigned err0);
  if (n_errors == err0) begin
    $display("test %s ok", name);
  end else begin
    $display("test %s %0d errors", name, n_errors - err0);
  end
endtask

`endif

//--- testbench/tb_vec_core.sv
// Testbench for the vector coprocessor
// Directed tests of VSETVL, broadcast, element ALU ops, reduction,
// tail handling and back-to-back issue against a shadow model

`timescale 1ns/1ps

module tb_vec_core import vec_pkg::*; ();

  localparam int unsigned TIMEOUT_CYCLES = 200;

  logic  clk_i;
  logic  rst_n_i;
  logic  insn_valid_i;
  logic  insn_ready_o;
  vop_e  insn_op_i;
  vreg_t insn_vd_i;
  vreg_t insn_vs1_i;
  vreg_t insn_vs2_i;
  elen_t insn_scalar_i;
  logic  resp_valid_o;
  elen_t resp_data_o;
  logic  idle_o;

  int unsigned n_errors   = 0;
  int unsigned n_checks   = 0;
  int unsigned resp_count = 0;

  vec_core dut0 (
    .clk_i         (clk_i        ),
    .rst_n_i       (rst_n_i      ),
    .insn_valid_i  (insn_valid_i ),
    .insn_ready_o  (insn_ready_o ),
    .insn_op_i     (insn_op_i    ),
    .insn_vd_i     (insn_vd_i    ),
    .insn_vs1_i    (insn_vs1_i   ),
    .insn_vs2_i    (insn_vs2_i   ),
    .insn_scalar_i (insn_scalar_i),
    .resp_valid_o  (resp_valid_o ),
    .resp_data_o   (resp_data_o  ),
    .idle_o        (idle_o       )
  );

  `include "tb_vec_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Every response pulse, sampled mid cycle
  always @(negedge clk_i) begin
    if (rst_n_i && resp_valid_o) begin
      resp_count <= resp_count + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_after_reset();
    int unsigned err0;
    err0 = n_errors;
    @(negedge clk_i);
    check_flag("reset idle_o", 1'b1, idle_o);
    check_flag("reset insn_ready_o", 1'b1, insn_ready_o);
    check_flag("reset resp_valid_o", 1'b0, resp_valid_o);
    set_vl("reset vsetvl 40", 32'd40);
    set_vl("reset vsetvl 5", 32'd5);
    report_test("after_reset", err0);
  endtask

  task automatic broadcast_and_move();
    int unsigned err0;
    elen_t       a;
    err0 = n_errors;
    a    = $urandom;
    set_vl("bcast vsetvl 16", 32'd16);
    issue_vec("bcast vmvx v1", VMVX, 3'd1, '0, '0, a);
    scalar_result("bcast vmvxs v1", VMVXS, 3'd1, '0, a);
    scalar_result("bcast vredsum v1", VREDSUM, 3'd1, '0, expected_redsum(3'd1, '0));
    report_test("broadcast", err0);
  endtask

  task automatic tail_undisturbed();
    int unsigned err0;
    err0 = n_errors;
    set_vl("tail vsetvl 16", 32'd16);
    issue_vec("tail vmvx 5", VMVX, 3'd2, '0, '0, 32'd5);
    set_vl("tail vsetvl 3", 32'd3);
    issue_vec("tail vmvx 7", VMVX, 3'd2, '0, '0, 32'd7);
    set_vl("tail vsetvl 16 again", 32'd16);
    // 3 body elements of 7 and 13 tail elements of 5
    scalar_result("tail vredsum v2", VREDSUM, 3'd2, '0, 32'd86);
    report_test("tail", err0);
  endtask

  task automatic alu_ops();
    int unsigned err0;
    vop_e        op_list [5] = '{VADD, VSUB, VAND, VOR, VXOR};
    elen_t       seed;
    string       name;
    err0 = n_errors;
    issue_vec("alu vmvx v3", VMVX, 3'd3, '0, '0, $urandom);
    issue_vec("alu vmvx v4", VMVX, 3'd4, '0, '0, $urandom);
    foreach (op_list[k]) begin
      seed = $urandom;
      name = $sformatf("alu %s", op_list[k].name());
      // v5 = v4 op v3
      issue_vec(name, op_list[k], 3'd5, 3'd3, 3'd4, '0);
      scalar_result(name, VREDSUM, 3'd5, seed, expected_redsum(3'd5, seed));
    end
    report_test("alu_ops", err0);
  endtask

  task automatic back_to_back();
    int unsigned err0;
    int unsigned count0;
    elen_t       seed;
    err0 = n_errors;
    seed = $urandom;
    set_vl("b2b vsetvl 11", 32'd11);
    // Let the counter take the VSETVL pulse first
    @(posedge clk_i);
    count0 = resp_count;
    issue_vec("b2b vadd", VADD, 3'd1, 3'd1, 3'd2, '0);
    issue_vec("b2b vsub", VSUB, 3'd2, 3'd3, 3'd1, '0);
    issue_vec("b2b vor", VOR, 3'd3, 3'd4, 3'd2, '0);
    issue_vec("b2b vmvx", VMVX, 3'd6, '0, '0, $urandom);
    issue_vec("b2b vxor", VXOR, 3'd5, 3'd6, 3'd3, '0);
    // VXOR sits in the slot or runs in the lanes here
    @(negedge clk_i);
    check_flag("b2b busy idle_o", 1'b0, idle_o);
    scalar_result("b2b vredsum", VREDSUM, 3'd5, seed, expected_redsum(3'd5, seed));
    wait_idle("b2b idle");
    repeat (4) @(posedge clk_i);
    check_count("b2b responses", 1, resp_count - count0);
    // Elements 11 and up of v5 must still hold their old values
    set_vl("b2b vsetvl 16", 32'd16);
    scalar_result("b2b tail vredsum", VREDSUM, 3'd5, '0, expected_redsum(3'd5, '0));
    report_test("back_to_back", err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(42));
    rst_n_i       = 1'b0;
    insn_valid_i  = 1'b0;
    insn_op_i     = VSETVL;
    insn_vd_i     = '0;
    insn_vs1_i    = '0;
    insn_vs2_i    = '0;
    insn_scalar_i = '0;
    model_vl      = vlen_t'(VLMAX);
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int i = 0; i < VLMAX; i++) begin
        model_rf[r][i] = '0;
      end
    end
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    check_after_reset();
    broadcast_and_move();
    tail_undisturbed();
    alu_ops();
    back_to_back();

    $display("tests 5, checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vec_core.f
+incdir+testbench
verilog/vec_pkg.sv
verilog/vec_if.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_reduce.sv
verilog/vec_core.sv
testbench/tb_vec_core.sv

//--- verilog/vec_core.sv
// Vector coprocessor top level
// Dispatcher, sequencer, replicated lanes and the scalar result unit

`timescale 1ns/1ps

module vec_core import vec_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  insn_valid_i,
  output logic  insn_ready_o,
  input  vop_e  insn_op_i,
  input  vreg_t insn_vd_i,
  input  vreg_t insn_vs1_i,
  input  vreg_t insn_vs2_i,
  input  elen_t insn_scalar_i,
  output logic  resp_valid_o,
  output elen_t resp_data_o,
  output logic  idle_o
);

  //////////////////////////////////////////////////////////////////////
  // Dispatcher to sequencer
  //////////////////////////////////////////////////////////////////////

  logic  seq_valid;
  logic  seq_ready;
  vop_e  seq_op;
  vreg_t seq_vd;
  vreg_t seq_vs1;
  vreg_t seq_vs2;
  vlen_t seq_vl;
  elen_t seq_scalar;
  logic  seq_idle;

  // Lanes and reducer
  logic [NR_LANES-1:0] lane_done;
  elen_t               lane_sum [NR_LANES];
  elen_t               elem0 [NR_LANES];
  vop_e                red_op;
  elen_t               red_seed;
  logic                red_valid;
  elen_t               red_data;

  vec_req_if lane_req_if ();

  vec_dispatcher i_dispatcher (
    .clk_i         (clk_i        ),
    .rst_n_i       (rst_n_i      ),
    .insn_valid_i  (insn_valid_i ),
    .insn_ready_o  (insn_ready_o ),
    .insn_op_i     (insn_op_i    ),
    .insn_vd_i     (insn_vd_i    ),
    .insn_vs1_i    (insn_vs1_i   ),
    .insn_vs2_i    (insn_vs2_i   ),
    .insn_scalar_i (insn_scalar_i),
    .seq_valid_o   (seq_valid    ),
    .seq_ready_i   (seq_ready    ),
    .seq_op_o      (seq_op       ),
    .seq_vd_o      (seq_vd       ),
    .seq_vs1_o     (seq_vs1      ),
    .seq_vs2_o     (seq_vs2      ),
    .seq_vl_o      (seq_vl       ),
    .seq_scalar_o  (seq_scalar   ),
    .seq_idle_i    (seq_idle     ),
    .red_valid_i   (red_valid    ),
    .red_data_i    (red_data     ),
    .resp_valid_o  (resp_valid_o ),
    .resp_data_o   (resp_data_o  )
  );

  vec_sequencer i_sequencer (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .req_valid_i  (seq_valid  ),
    .req_ready_o  (seq_ready  ),
    .req_op_i     (seq_op     ),
    .req_vd_i     (seq_vd     ),
    .req_vs1_i    (seq_vs1    ),
    .req_vs2_i    (seq_vs2    ),
    .req_vl_i     (seq_vl     ),
    .req_scalar_i (seq_scalar ),
    .idle_o       (seq_idle   ),
    .lane_req     (lane_req_if),
    .lane_done_i  (lane_done  ),
    .red_op_o     (red_op     ),
    .red_seed_o   (red_seed   )
  );

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID(l)
    ) i_lane (
      .clk_i       (clk_i       ),
      .rst_n_i     (rst_n_i     ),
      .bcast_i     (red_seed    ),
      .req         (lane_req_if ),
      .lane_done_o (lane_done[l]),
      .lane_sum_o  (lane_sum[l] ),
      .elem0_o     (elem0[l]    )
    );
  end : gen_lanes

  vec_reduce i_reduce (
    .clk_i       (clk_i    ),
    .rst_n_i     (rst_n_i  ),
    .lane_done_i (lane_done),
    .lane_sum_i  (lane_sum ),
    .elem0_i     (elem0[0] ),
    .red_op_i    (red_op   ),
    .red_seed_i  (red_seed ),
    .red_valid_o (red_valid),
    .red_data_o  (red_data )
  );

  // Nothing executing and nothing waiting in the slot
  assign idle_o = seq_idle & ~seq_valid;

endmodule

//--- verilog/vec_dispatcher.sv
// Instruction dispatcher
// Accepts host instructions, owns the vector length, executes VSETVL itself
// and forwards vector work through a one-entry slot to the sequencer

`timescale 1ns/1ps

module vec_dispatcher import vec_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Host instruction port
  input  logic  insn_valid_i,
  output logic  insn_ready_o,
  input  vop_e  insn_op_i,
  input  vreg_t insn_vd_i,
  input  vreg_t insn_vs1_i,
  input  vreg_t insn_vs2_i,
  input  elen_t insn_scalar_i,
  // Request to the sequencer
  output logic  seq_valid_o,
  input  logic  seq_ready_i,
  output vop_e  seq_op_o,
  output vreg_t seq_vd_o,
  output vreg_t seq_vs1_o,
  output vreg_t seq_vs2_o,
  output vlen_t seq_vl_o,
  output elen_t seq_scalar_o,
  input  logic  seq_idle_i,
  // Scalar result from the reducer
  input  logic  red_valid_i,
  input  elen_t red_data_i,
  // Host response port
  output logic  resp_valid_o,
  output elen_t resp_data_o
);

  logic  slot_valid_q;
  vop_e  slot_op_q;
  vreg_t slot_vd_q;
  vreg_t slot_vs1_q;
  vreg_t slot_vs2_q;
  vlen_t slot_vl_q;
  elen_t slot_scalar_q;
  vlen_t vl_q;
  vlen_t vl_new;
  logic  setvl_resp_q;
  logic  is_setvl;
  logic  accept;

  assign is_setvl = (insn_op_i == VSETVL);

  // VSETVL waits until everything ahead of it has drained
  assign insn_ready_o = !slot_valid_q && (!is_setvl || seq_idle_i);
  assign accept       = insn_valid_i && insn_ready_o;

  // Requested length clamped to the register size
  assign vl_new = (insn_scalar_i > elen_t'(VLMAX)) ? vlen_t'(VLMAX) : vlen_t'(insn_scalar_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vl_q         <= vlen_t'(VLMAX);
      slot_valid_q <= 1'b0;
      setvl_resp_q <= 1'b0;
    end else begin
      setvl_resp_q <= accept && is_setvl;
      if (accept && is_setvl) begin
        vl_q <= vl_new;
      end
      if (accept && !is_setvl) begin
        slot_valid_q <= 1'b1;
      end else if (seq_ready_i) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  // Slot payload, stamped with the vl in force at acceptance
  always_ff @(posedge clk_i) begin
    if (accept && !is_setvl) begin
      slot_op_q     <= insn_op_i;
      slot_vd_q     <= insn_vd_i;
      slot_vs1_q    <= insn_vs1_i;
      slot_vs2_q    <= insn_vs2_i;
      slot_vl_q     <= vl_q;
      slot_scalar_q <= insn_scalar_i;
    end
  end

  assign seq_valid_o  = slot_valid_q;
  assign seq_op_o     = slot_op_q;
  assign seq_vd_o     = slot_vd_q;
  assign seq_vs1_o    = slot_vs1_q;
  assign seq_vs2_o    = slot_vs2_q;
  assign seq_vl_o     = slot_vl_q;
  assign seq_scalar_o = slot_scalar_q;

  // The two response sources never overlap in time
  assign resp_valid_o = setvl_resp_q | red_valid_i;
  assign resp_data_o  = setvl_resp_q ? elen_t'(vl_q) : red_data_i;

  a_vl_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vl_q <= vlen_t'(VLMAX));

endmodule

//--- verilog/vec_if.sv
// Sequencer to lane request
// One request is broadcast to all lanes, each lane answers with a ready bit

`timescale 1ns/1ps

interface vec_req_if import vec_pkg::*; ();

  // Request broadcast by the sequencer
  logic  valid;
  vop_e  op;
  vreg_t vd;
  vreg_t vs1;
  vreg_t vs2;
  vlen_t vl;

  // One bit per lane, each driven by its own lane
  wire [NR_LANES-1:0] lane_ready;

  modport seq (
    output valid,
    output op,
    output vd,
    output vs1,
    output vs2,
    output vl,
    input  lane_ready
  );

  modport lane (
    input  valid,
    input  op,
    input  vd,
    input  vs1,
    input  vs2,
    input  vl,
    output lane_ready
  );

endinterface

//--- verilog/vec_lane.sv
// Vector lane
// Holds this lane's slice of every vector register, steps through its
// element slots with a 32-bit ALU and accumulates a partial sum for VREDSUM

`timescale 1ns/1ps

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  elen_t  bcast_i,
  vec_req_if.lane req,
  output logic   lane_done_o,
  output elen_t  lane_sum_o,
  output elen_t  elem0_o
);

  // Register file slice, no reset
  elen_t rf_q [NR_VREGS][ELEMS_PER_LANE];

  lane_state_e state_q;
  slot_t       slot_q;
  logic        done_q;
  vop_e        op_q;
  vreg_t       vd_q;
  vreg_t       vs1_q;
  vreg_t       vs2_q;
  vlen_t       vl_q;
  elen_t       sum_q;
  elen_t       vs1_elem;
  elen_t       vs2_elem;
  elen_t       alu_res;
  vlen_t       elem_idx;
  logic        active;
  logic        writes_vd;
  logic        rf_we;
  logic        xfer;

  assign req.lane_ready[LANE_ID] = (state_q == L_IDLE);
  assign xfer = req.valid && (&req.lane_ready);

  // Global element index of the current slot
  assign elem_idx = vlen_t'(slot_q) * vlen_t'(NR_LANES) + vlen_t'(LANE_ID);
  assign active   = (state_q == L_RUN) && (elem_idx < vl_q);

  assign vs1_elem = rf_q[vs1_q][slot_q];
  assign vs2_elem = rf_q[vs2_q][slot_q];

  // Element ALU, vd = vs2 op vs1
  always_comb begin
    case (op_q)
      VMVX:    alu_res = bcast_i;
      VADD:    alu_res = vs2_elem + vs1_elem;
      VSUB:    alu_res = vs2_elem - vs1_elem;
      VAND:    alu_res = vs2_elem & vs1_elem;
      VOR:     alu_res = vs2_elem | vs1_elem;
      VXOR:    alu_res = vs2_elem ^ vs1_elem;
      default: alu_res = vs2_elem;
    endcase
  end

  assign writes_vd = op_q inside {VMVX, VADD, VSUB, VAND, VOR, VXOR};
  // Tail elements are never written
  assign rf_we     = active && writes_vd;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= L_IDLE;
      slot_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q == L_IDLE) begin
        if (xfer) begin
          state_q <= L_RUN;
          slot_q  <= '0;
        end
      end else begin
        slot_q <= slot_q + 1'b1;
        if (slot_q == slot_t'(ELEMS_PER_LANE - 1)) begin
          state_q <= L_IDLE;
          done_q  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      op_q  <= req.op;
      vd_q  <= req.vd;
      vs1_q <= req.vs1;
      vs2_q <= req.vs2;
      vl_q  <= req.vl;
      sum_q <= '0;
    end else if (active && op_q == VREDSUM) begin
      sum_q <= sum_q + vs2_elem;
    end
    if (rf_we) begin
      rf_q[vd_q][slot_q] <= alu_res;
    end
  end

  assign lane_done_o = done_q;
  assign lane_sum_o  = sum_q;
  assign elem0_o     = rf_q[vs2_q][0];

  // An idle lane leaves the element at its write address untouched
  a_no_idle_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q == L_IDLE && !xfer |=> $stable(rf_q[vd_q][slot_q]));

  // Done comes a fixed number of cycles after the request
  a_done_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    xfer |-> ##(ELEMS_PER_LANE + 1) done_q);

endmodule

//--- verilog/vec_pkg.sv
// Vector coprocessor package
// Sizes, element and index types, and the instruction opcodes
// shared by the dispatcher, sequencer, lanes and reducer

package vec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Lanes and elements held per lane for each register
  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEMS_PER_LANE = 4;

  // Element i lives in lane i mod NR_LANES, slot i div NR_LANES
  localparam int unsigned VLMAX = NR_LANES * ELEMS_PER_LANE;

  localparam int unsigned ELEN     = 32;
  localparam int unsigned NR_VREGS = 8;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // One element or scalar operand
  typedef logic [ELEN-1:0] elen_t;

  // Vector register index
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;

  // Vector length, 0 up to and including VLMAX
  typedef logic [$clog2(VLMAX+1)-1:0] vlen_t;

  // Slot of an element inside one lane
  typedef logic [$clog2(ELEMS_PER_LANE)-1:0] slot_t;

  // Instruction opcodes
  typedef enum logic [3:0] {
    VSETVL  = 4'd0,
    VMVX    = 4'd1,
    VADD    = 4'd2,
    VSUB    = 4'd3,
    VAND    = 4'd4,
    VOR     = 4'd5,
    VXOR    = 4'd6,
    VREDSUM = 4'd7,
    VMVXS   = 4'd8
  } vop_e;

  // Lane FSM
  typedef enum logic {
    L_IDLE = 1'b0,
    L_RUN  = 1'b1
  } lane_state_e;

endpackage

//--- verilog/vec_reduce.sv
// Scalar result unit
// Gathers the lane done pulses, then adds the seed to the lane partial
// sums for VREDSUM or picks element 0 for VMVXS, and registers the result

`timescale 1ns/1ps

module vec_reduce import vec_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [NR_LANES-1:0] lane_done_i,
  input  elen_t              lane_sum_i [NR_LANES],
  input  elen_t              elem0_i,
  input  vop_e               red_op_i,
  input  elen_t              red_seed_i,
  output logic               red_valid_o,
  output elen_t              red_data_o
);

  logic [NR_LANES-1:0] done_seen_q;
  logic                all_done;
  logic                wants_scalar;
  logic                red_valid_q;
  elen_t               red_data_q;
  elen_t               sum;

  assign all_done     = &(done_seen_q | lane_done_i);
  assign wants_scalar = (red_op_i == VREDSUM) || (red_op_i == VMVXS);

  // Seed plus every lane's partial sum, wrapping at 32 bits
  always_comb begin
    sum = red_seed_i;
    for (int l = 0; l < NR_LANES; l++) begin
      sum = sum + lane_sum_i[l];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_seen_q <= '0;
      red_valid_q <= 1'b0;
    end else begin
      red_valid_q <= all_done && wants_scalar;
      if (all_done) begin
        done_seen_q <= '0;
      end else begin
        done_seen_q <= done_seen_q | lane_done_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (all_done) begin
      red_data_q <= (red_op_i == VMVXS) ? elem0_i : sum;
    end
  end

  assign red_valid_o = red_valid_q;
  assign red_data_o  = red_data_q;

endmodule

//--- verilog/vec_sequencer.sv
// Sequencer
// Issues one vector instruction at a time to all lanes and waits
// for every lane to report completion

`timescale 1ns/1ps

module vec_sequencer import vec_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request from the dispatcher
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vop_e               req_op_i,
  input  vreg_t              req_vd_i,
  input  vreg_t              req_vs1_i,
  input  vreg_t              req_vs2_i,
  input  vlen_t              req_vl_i,
  input  elen_t              req_scalar_i,
  output logic               idle_o,
  // Lanes
  vec_req_if.seq             lane_req,
  input  logic [NR_LANES-1:0] lane_done_i,
  // Instruction in flight, for the reducer and the VMVX broadcast
  output vop_e               red_op_o,
  output elen_t              red_seed_o
);

  logic                valid_q;
  logic                busy_q;
  logic [NR_LANES-1:0] done_seen_q;
  vop_e                op_q;
  vreg_t               vd_q;
  vreg_t               vs1_q;
  vreg_t               vs2_q;
  vlen_t               vl_q;
  elen_t               scalar_q;
  logic                accept;
  logic                xfer;
  logic                all_done;

  assign req_ready_o = !valid_q && !busy_q;
  assign idle_o      = !valid_q && !busy_q;
  assign accept      = req_valid_i && req_ready_o;
  assign xfer        = valid_q && (&lane_req.lane_ready);
  assign all_done    = &(done_seen_q | lane_done_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q     <= 1'b0;
      busy_q      <= 1'b0;
      done_seen_q <= '0;
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
      end else if (xfer) begin
        valid_q <= 1'b0;
      end
      if (xfer) begin
        busy_q      <= 1'b1;
        done_seen_q <= '0;
      end else if (busy_q) begin
        if (all_done) begin
          busy_q      <= 1'b0;
          done_seen_q <= '0;
        end else begin
          done_seen_q <= done_seen_q | lane_done_i;
        end
      end
    end
  end

  // Held until the next accept, which cannot happen before all lanes are done
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= req_op_i;
      vd_q     <= req_vd_i;
      vs1_q    <= req_vs1_i;
      vs2_q    <= req_vs2_i;
      vl_q     <= req_vl_i;
      scalar_q <= req_scalar_i;
    end
  end

  assign lane_req.valid = valid_q;
  assign lane_req.op    = op_q;
  assign lane_req.vd    = vd_q;
  assign lane_req.vs1   = vs1_q;
  assign lane_req.vs2   = vs2_q;
  assign lane_req.vl    = vl_q;

  assign red_op_o   = op_q;
  assign red_seed_o = scalar_q;

  // A stalled request keeps its valid and fields
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_req.valid && !(&lane_req.lane_ready) |=>
      lane_req.valid && $stable(lane_req.op) && $stable(lane_req.vd) &&
      $stable(lane_req.vs1) && $stable(lane_req.vs2) && $stable(lane_req.vl));

endmodule
